/* mpeg_dvc.f */
dvc_regmap_pkg.sv
dvc_timing_pkg.sv
dvc_dma_control.sv
dvc_clock_timer.sv
dvc_registers.sv
dvc_byte_splitter.sv
mpeg_dvc.sv
tb_mpeg_dvc.sv

/* Makefile */
TOP := tb_mpeg_dvc
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mpeg_dvc.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mpeg_dvc.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --top-module mpeg_dvc dvc_regmap_pkg.sv dvc_timing_pkg.sv \
		dvc_dma_control.sv dvc_clock_timer.sv dvc_registers.sv dvc_byte_splitter.sv mpeg_dvc.sv

clean:
	rm -rf obj_dir $(LOG)

/* tb_mpeg_dvc.sv */
`timescale 1ns/100ps

module tb_mpeg_dvc
    import dvc_regmap_pkg::*, dvc_timing_pkg::*;
();

    logic        clk;
    logic        reset;
    logic [14:0] address;
    logic [15:0] din;
    logic [15:0] dout;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        cs;
    logic        bus_ack;
    logic        intreq;
    logic        intack;
    logic        req;
    logic        ack;
    logic        rdy;
    logic        dtc;
    logic        done_in;
    logic        vsync;
    logic        event_sequence;
    logic        event_gop;
    logic        event_picture;
    logic        event_decoding_started;
    logic        event_frame_decoded;
    logic        event_underflow;
    logic [7:0]  stream_byte;
    logic        stream_valid;
    logic        stream_audio;

    // Reference model state
    logic [15:0] model_fma_isr;
    logic [15:0] model_fma_status;
    logic [15:0] model_fma_ier;
    logic [15:0] model_fma_ivec;
    logic [15:0] model_fmv_ier;
    logic [15:0] model_fmv_ivec;
    fmv_irq_u    model_fmv_isr;
    logic [8:0]  expected_bytes[$];  // {audio tag, byte}
    logic [8:0]  next_byte;

    logic [31:0] rand_state;
    int unsigned cycle_count;
    int unsigned commit_cycles;  // Cycle count seen in the last commit cycle

    mpeg_dvc i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (reset) cycle_count <= 0;
        else cycle_count <= cycle_count + 1;
    end

    task automatic fail_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic int rand_below(input int limit);
        return int'(next_random() >> 16) % limit;  // Upper bits are the better ones
    endfunction

    function automatic logic expected_intreq();
        return ((model_fma_isr & model_fma_ier) != 16'h0) ||
               ((model_fmv_isr.raw & model_fmv_ier) != 16'h0);
    endfunction

    function automatic logic [15:0] expected_vector();
        if ((model_fma_isr & model_fma_ier) != 16'h0) return {2{model_fma_ivec[7:0]}};
        return {2{model_fmv_ivec[10:3]}};
    endfunction

    // Stream check, sampled before the edge updates anything
    always @(posedge clk) begin
        if (!reset && stream_valid) begin
            if (expected_bytes.size() == 0) fail_run("Stream byte came out with none expected");
            next_byte = expected_bytes.pop_front();
            check_value("stream byte", {stream_audio, stream_byte}, next_byte);
        end
    end

    task automatic bus_access(input logic wr, input logic [14:0] addr, input logic [15:0] data,
                              output logic [15:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        cs           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        write_strobe = wr;
        address      = addr;
        din          = data;
        @(negedge clk);
        while (!bus_ack) begin
            if (n == 8) fail_run("bus_ack never rose");
            @(negedge clk);
            n++;
        end
        rdata         = dout;  // Commit cycle
        commit_cycles = cycle_count;
        @(negedge clk);
        cs           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        din          = 16'h0;
    endtask

    task automatic bus_write(input logic [14:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [14:0] addr, output logic [15:0] data);
        bus_access(1'b0, addr, 16'h0, data);
    endtask

    task automatic apply_event(input int kind);
        @(negedge clk);
        case (kind)
            0: event_sequence = 1'b1;
            1: event_gop = 1'b1;
            2: event_picture = 1'b1;
            3: event_decoding_started = 1'b1;
            4: event_frame_decoded = 1'b1;
            5: event_underflow = 1'b1;
            default: vsync = 1'b1;
        endcase
        @(negedge clk);
        event_sequence         = 1'b0;
        event_gop              = 1'b0;
        event_picture          = 1'b0;
        event_decoding_started = 1'b0;
        event_frame_decoded    = 1'b0;
        event_underflow        = 1'b0;
        vsync                  = 1'b0;
        case (kind)
            0: model_fmv_isr.flags.seq = 1'b1;
            1: model_fmv_isr.flags.gop = 1'b1;
            2: model_fmv_isr.flags.pic = 1'b1;
            3: begin
                model_fma_status[4] = 1'b1;
                model_fma_isr[4]    = 1'b1;
            end
            4: begin
                model_fma_status[4] = 1'b0;
                model_fma_status[2] = 1'b1;
                model_fma_isr[2]    = 1'b1;
            end
            5: begin
                model_fma_status[3] = 1'b1;
                model_fma_isr[3]    = 1'b1;
            end
            default: model_fmv_isr.flags.vsync = 1'b1;
        endcase
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (req !== level) begin
            if (n == 10) fail_run("req did not reach the expected level");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic send_dma_word(input logic [15:0] data, input logic audio);
        @(negedge clk);
        expected_bytes.push_back({audio, data[15:8]});
        expected_bytes.push_back({audio, data[7:0]});
        ack = 1'b1;
        dtc = 1'b1;
        din = data;
        @(negedge clk);
        ack = 1'b0;
        dtc = 1'b0;
        din = 16'h0;
        repeat (rand_below(3)) @(negedge clk);
    endtask

    task automatic finish_dma();
        @(negedge clk);
        done_in = 1'b1;
        ack     = 1'b1;
        @(negedge clk);
        done_in = 1'b0;
        ack     = 1'b0;
        wait_req(1'b0);
        check_value("rdy after done", rdy, 1'b0);
    endtask

    task automatic xfer_word(input logic [15:0] data);
        expected_bytes.push_back({1'b0, data[15:8]});
        expected_bytes.push_back({1'b0, data[7:0]});
        bus_write(addr_fmv_xfer, data);
    endtask

    initial begin
        logic [15:0] rdata;
        logic [15:0] tcnt_value;
        logic [31:0] ticks;
        int          n;
        clk = 1'b0;
        reset = 1'b1;
        address = '0;
        din = '0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
        cs = 1'b0;
        intack = 1'b0;
        ack = 1'b0;
        dtc = 1'b0;
        done_in = 1'b0;
        vsync = 1'b0;
        event_sequence = 1'b0;
        event_gop = 1'b0;
        event_picture = 1'b0;
        event_decoding_started = 1'b0;
        event_frame_decoded = 1'b0;
        event_underflow = 1'b0;
        rand_state = 32'd60377;
        model_fma_isr = '0;
        model_fma_status = '0;
        model_fmv_isr.raw = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Register write and read back
        repeat (4) begin
            model_fma_ivec = 16'(next_random());
            model_fma_ier  = 16'(next_random());
            model_fmv_ier  = 16'(next_random());
            model_fmv_ivec = 16'(next_random());
            tcnt_value     = 16'(next_random()) | 16'h8000;  // Keeps the timer quiet
            bus_write(addr_fma_ivec, model_fma_ivec);
            bus_write(addr_fma_ier, model_fma_ier);
            bus_write(addr_fmv_ier, model_fmv_ier);
            bus_write(addr_fmv_ivec, model_fmv_ivec);
            bus_write(addr_fmv_tcnt, tcnt_value);
            bus_read(addr_fma_ivec, rdata);
            check_value("FMA IVEC", rdata, model_fma_ivec);
            bus_read(addr_fma_ier, rdata);
            check_value("FMA IER", rdata, model_fma_ier);
            bus_read(addr_fmv_ier, rdata);
            check_value("FMV IER", rdata, model_fmv_ier);
            bus_read(addr_fmv_ivec, rdata);
            check_value("FMV IVEC", rdata, model_fmv_ivec);
            bus_read(addr_fmv_tcnt, rdata);
            check_value("TCNT", rdata, tcnt_value);
        end

        // Events, interrupt request, vector and read clear
        for (int i = 0; i < 40; i++) begin
            apply_event(rand_below(7));
            check_value("intreq", intreq, expected_intreq());
            intack = 1'b1;
            @(negedge clk);
            check_value("intack vector", dout, expected_vector());
            intack = 1'b0;
            case (rand_below(4))
                0: begin
                    bus_read(addr_fma_isr, rdata);
                    check_value("FMA ISR", rdata, model_fma_isr);
                    model_fma_isr = '0;
                end
                1: begin
                    bus_read(addr_fmv_isr, rdata);
                    check_value("FMV ISR", rdata, model_fmv_isr.raw);
                    model_fmv_isr.raw = '0;
                end
                2: begin
                    bus_read(addr_fma_stat, rdata);
                    check_value("FMA STAT", rdata, model_fma_status);
                end
                default: ;
            endcase
        end

        // Audio DMA
        bus_write(addr_fma_cmd, 16'h8002);
        wait_req(1'b1);
        check_value("rdy", rdy, 1'b1);
        repeat (6) send_dma_word(16'(next_random()), 1'b1);
        finish_dma();
        bus_read(addr_fma_cmd, rdata);
        check_value("FMA CMD after DMA", rdata, 16'h0002);

        // Video DMA then PIO words
        bus_write(addr_fmv_syscmd, fmv_syscmd_dma);
        wait_req(1'b1);
        repeat (6) send_dma_word(16'(next_random()), 1'b0);
        finish_dma();
        repeat (5) xfer_word(16'(next_random()));
        repeat (3) @(negedge clk);
        check_value("bytes still expected", expected_bytes.size(), 0);

        // System timer
        model_fmv_ier = 16'h0100;
        model_fma_ier = 16'h0000;
        bus_write(addr_fmv_ier, model_fmv_ier);
        bus_write(addr_fma_ier, model_fma_ier);
        bus_write(addr_fmv_tcnt, 16'h0001);
        bus_write(addr_fmv_trld, 16'h0000);
        bus_read(addr_fma_isr, rdata);
        bus_read(addr_fmv_isr, rdata);
        model_fma_isr = '0;
        model_fmv_isr.raw = '0;
        n = 0;
        while (!intreq) begin
            if (n == 12 * dclk_prescale) fail_run("Timer interrupt never came");
            @(negedge clk);
            n++;
        end
        model_fmv_isr.flags.tim = 1'b1;
        model_fma_isr[fma_bit_poll] = 1'b1;
        bus_read(addr_fmv_isr, rdata);
        check_value("FMV ISR after timer", rdata, model_fmv_isr.raw);
        bus_read(addr_fma_isr, rdata);
        check_value("FMA ISR after timer", rdata, model_fma_isr);

        // Decoder clock against elapsed cycles
        repeat (2) begin
            repeat (rand_below(2000)) @(negedge clk);
            bus_read(addr_fma_dclkh, rdata);
            ticks = commit_cycles / dclk_prescale;
            check_value("DCLKH", rdata, ticks[31:16]);
            bus_read(addr_fma_dclkl, rdata);
            check_value("DCLKL", rdata, ticks[15:0]);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* mpeg_dvc.sv */
`timescale 1ns/100ps

module mpeg_dvc (
    input  logic        clk,
    input  logic        reset,
    input  logic [14:0] address,
    input  logic [15:0] din,
    output logic [15:0] dout,
    input  logic        uds,
    input  logic        lds,
    input  logic        write_strobe,
    input  logic        cs,
    output logic        bus_ack,
    output logic        intreq,
    input  logic        intack,
    output logic        req,
    input  logic        ack,
    output logic        rdy,
    input  logic        dtc,
    input  logic        done_in,
    input  logic        vsync,
    input  logic        event_sequence,
    input  logic        event_gop,
    input  logic        event_picture,
    input  logic        event_decoding_started,
    input  logic        event_frame_decoded,
    input  logic        event_underflow,
    output logic [7:0]  stream_byte,
    output logic        stream_valid,
    output logic        stream_audio
);

    logic        fma_dma_start;
    logic        fmv_dma_start;
    logic        xfer_write;
    logic        timer_reload;
    logic [15:0] timer_compare;
    logic [31:0] dclk;
    logic        timer_event;
    logic        dma_for_fma;
    logic        dma_done;

    dvc_registers i_registers (
        .clk, .reset, .address, .din, .uds, .lds, .cs, .write_strobe, .intack, .vsync,
        .event_sequence, .event_gop, .event_picture,
        .event_decoding_started, .event_frame_decoded, .event_underflow,
        .dclk, .timer_event, .dma_for_fma, .dma_done,
        .dout, .bus_ack, .intreq,
        .fma_dma_start, .fmv_dma_start, .xfer_write, .timer_reload, .timer_compare
    );

    dvc_dma_control i_dma_control (
        .clk, .reset, .fma_dma_start, .fmv_dma_start, .ack, .done_in,
        .req, .rdy, .dma_for_fma, .dma_done
    );

    dvc_clock_timer i_clock_timer (
        .clk, .reset, .timer_reload, .timer_compare, .dclk, .timer_event
    );

    dvc_byte_splitter i_byte_splitter (
        .clk, .reset, .din, .ack, .dtc, .xfer_write, .dma_for_fma,
        .stream_byte, .stream_valid, .stream_audio
    );

endmodule

/* dvc_byte_splitter.sv */
`timescale 1ns/100ps

module dvc_byte_splitter (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] din,
    input  logic        ack,
    input  logic        dtc,
    input  logic        xfer_write,
    input  logic        dma_for_fma,
    output logic [7:0]  stream_byte,
    output logic        stream_valid,
    output logic        stream_audio
);

    logic       word_valid;
    logic       word_valid_q;
    logic [7:0] low_byte_q;
    logic       audio_q;

    assign word_valid = (ack && dtc) || xfer_write;  // DMA word or PIO write

    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid_q <= 1'b0;
            low_byte_q   <= '0;
            audio_q      <= 1'b0;
        end else begin
            word_valid_q <= word_valid;
            if (word_valid) begin
                low_byte_q <= din[7:0];
                audio_q    <= dma_for_fma;  // Tag held for the second byte
            end
        end
    end

    // High byte goes out first
    assign stream_byte  = word_valid_q ? low_byte_q : din[15:8];
    assign stream_valid = word_valid || word_valid_q;
    assign stream_audio = word_valid_q ? audio_q : dma_for_fma;

    assert property (@(posedge clk) disable iff (reset) word_valid |=> !word_valid);

endmodule

/* dvc_registers.sv */
`timescale 1ns/100ps

module dvc_registers import dvc_regmap_pkg::*, dvc_timing_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [14:0] address,
    input  logic [15:0] din,
    input  logic        uds,
    input  logic        lds,
    input  logic        cs,
    input  logic        write_strobe,
    input  logic        intack,
    input  logic        vsync,
    input  logic        event_sequence,
    input  logic        event_gop,
    input  logic        event_picture,
    input  logic        event_decoding_started,
    input  logic        event_frame_decoded,
    input  logic        event_underflow,
    input  logic [31:0] dclk,
    input  logic        timer_event,
    input  logic        dma_for_fma,
    input  logic        dma_done,
    output logic [15:0] dout,
    output logic        bus_ack,
    output logic        intreq,
    output logic        fma_dma_start,
    output logic        fmv_dma_start,
    output logic        xfer_write,
    output logic        timer_reload,
    output logic [15:0] timer_compare
);

    logic        access;
    logic        bus_wr;
    logic        bus_rd;
    logic        vsync_q;
    logic        vsync_rise;
    logic        fma_intreq;
    logic        fmv_intreq;

    logic [15:0] fma_cmd;
    logic [15:0] fma_status;
    logic [15:0] fma_ivec;
    logic [15:0] fma_isr;
    logic [15:0] fma_ier;
    logic [15:0] dclkl_latch;
    logic [15:0] fmv_ier;
    logic [15:0] fmv_ivec;
    fmv_irq_u    fmv_isr;

    assign access = cs && (uds || lds);
    assign bus_wr = access && bus_ack && write_strobe;  // Commit cycle
    assign bus_rd = access && bus_ack && !write_strobe;

    assign vsync_rise = vsync && !vsync_q;

    // One-cycle command strobes
    assign fma_dma_start = bus_wr && (address == addr_fma_cmd) && din[fma_cmd_dma_bit];
    assign fmv_dma_start = bus_wr && (address == addr_fmv_syscmd) && (din == fmv_syscmd_dma);
    assign xfer_write    = bus_wr && (address == addr_fmv_xfer);
    assign timer_reload  = bus_wr && (address == addr_fmv_trld);

    assign fma_intreq = (fma_isr & fma_ier) != '0;
    assign fmv_intreq = (fmv_isr.raw & fmv_ier) != '0;
    assign intreq     = fma_intreq || fmv_intreq;

    always_comb begin
        dout = '0;
        case (address)
            addr_fma_cmd:   dout = fma_cmd;
            addr_fma_stat:  dout = fma_status;
            addr_fma_ivec:  dout = fma_ivec;
            addr_fma_dclkh: dout = dclk[31:16];
            addr_fma_dclkl: dout = dclkl_latch;
            addr_fma_isr:   dout = fma_isr;
            addr_fma_ier:   dout = fma_ier;
            addr_fmv_ier:   dout = fmv_ier;
            addr_fmv_isr:   dout = fmv_isr.raw;
            addr_fmv_tcnt:  dout = timer_compare;
            addr_fmv_ivec:  dout = fmv_ivec;
            default: ;
        endcase

        // Audio side wins the interrupt acknowledge
        if (intack) begin
            if (fma_intreq) begin
                dout = {fma_ivec[7:0], fma_ivec[7:0]};
            end else begin
                dout = {fmv_ivec[10:3], fmv_ivec[10:3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack       <= 1'b0;
            vsync_q       <= 1'b0;
            fma_cmd       <= '0;
            fma_status    <= '0;
            fma_ivec      <= '0;
            fma_isr       <= '0;
            fma_ier       <= '0;
            dclkl_latch   <= '0;
            fmv_ier       <= '0;
            fmv_ivec      <= '0;
            fmv_isr.raw   <= '0;
            timer_compare <= tcnt_reset;
        end else begin
            vsync_q <= vsync;
            bus_ack <= access ? !bus_ack : 1'b0;

            if (vsync_rise)     fmv_isr.flags.vsync <= 1'b1;
            if (event_sequence) fmv_isr.flags.seq <= 1'b1;
            if (event_gop)      fmv_isr.flags.gop <= 1'b1;
            if (event_picture)  fmv_isr.flags.pic <= 1'b1;

            if (timer_event) begin
                fmv_isr.flags.tim     <= 1'b1;
                fma_isr[fma_bit_poll] <= 1'b1;
            end

            if (event_decoding_started) begin
                fma_status[fma_bit_dec] <= 1'b1;
                fma_isr[fma_bit_dec]    <= 1'b1;
            end

            if (event_frame_decoded) begin
                fma_status[fma_bit_dec] <= 1'b0;  // Decoding no longer pending
                fma_status[fma_bit_upd] <= 1'b1;
                fma_isr[fma_bit_upd]    <= 1'b1;
            end

            if (event_underflow) begin
                fma_status[fma_bit_unf] <= 1'b1;
                fma_isr[fma_bit_unf]    <= 1'b1;
            end

            if (dma_done) fma_cmd[fma_cmd_dma_bit] <= 1'b0;

            // Read side effects come last so a clear beats a set
            if (bus_rd) begin
                case (address)
                    addr_fmv_isr:   fmv_isr.raw <= '0;
                    addr_fma_isr:   fma_isr <= '0;
                    addr_fma_dclkh: dclkl_latch <= dclk[15:0];
                    default: ;
                endcase
            end

            if (bus_wr) begin
                case (address)
                    addr_fma_cmd:  fma_cmd <= din;
                    addr_fma_ivec: fma_ivec <= din;
                    addr_fma_ier:  fma_ier <= din;
                    addr_fmv_ier:  fmv_ier <= din;
                    addr_fmv_tcnt: timer_compare <= din;
                    addr_fmv_ivec: fmv_ivec <= din;
                    default: ;
                endcase
            end
        end
    end

    // Audio DMA start selects the audio target
    assert property (@(posedge clk) disable iff (reset)
        fma_dma_start |=> dma_for_fma);

endmodule

/* dvc_clock_timer.sv */
`timescale 1ns/100ps

module dvc_clock_timer import dvc_timing_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  timer_reload,
    input  logic [15:0]           timer_compare,
    output logic [dclk_width-1:0] dclk,
    output logic                  timer_event
);

    logic [dclk_prescale_width-1:0] prescale_cnt;
    logic [timer_cnt_width-1:0]     timer_cnt;
    logic                           tick;
    logic                           compare_hit;

    assign tick = (prescale_cnt == dclk_prescale_width'(dclk_prescale - 1));

    // Upper field only, low bits give 8 ticks per compare step
    assign compare_hit = (timer_cnt[timer_frac_bits +: timer_cmp_width] == timer_compare);
    assign timer_event = tick && compare_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale_cnt <= '0;
            dclk         <= '0;
            timer_cnt    <= '0;
        end else begin
            if (tick) begin
                prescale_cnt <= '0;
                dclk         <= dclk + 1'b1;
            end else begin
                prescale_cnt <= prescale_cnt + 1'b1;
            end

            if (timer_reload) begin
                timer_cnt <= '0;
            end else if (tick) begin
                timer_cnt <= compare_hit ? '0 : timer_cnt + 1'b1;
            end
        end
    end

    // Timer events line up with a decoder clock step
    assert property (@(posedge clk) disable iff (reset)
        timer_event |=> (dclk == $past(dclk) + 1'b1));

endmodule

/* dvc_dma_control.sv */
`timescale 1ns/100ps

module dvc_dma_control import dvc_regmap_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic fma_dma_start,
    input  logic fmv_dma_start,
    input  logic ack,
    input  logic done_in,
    output logic req,
    output logic rdy,
    output logic dma_for_fma,
    output logic dma_done
);

    logic [1:0] state;
    logic       done_hit;
    logic       any_start;

    assign done_hit  = done_in && ack;
    assign any_start = fma_dma_start || fmv_dma_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= dma_idle;
            dma_done <= 1'b0;
        end else begin
            // A new start overrides the end of the previous transfer
            dma_done <= done_hit && !any_start;

            if (fma_dma_start) begin
                state <= dma_audio;
            end else if (fmv_dma_start) begin
                state <= dma_video;
            end else if (done_hit) begin
                state <= dma_idle;
            end
        end
    end

    assign req         = (state != dma_idle);
    assign rdy         = (state != dma_idle);  // Host ready for the whole transfer
    assign dma_for_fma = (state == dma_audio);

    // Request only drops on end of transfer
    assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && $fell(req)) |-> $past(done_in && ack));

endmodule

/* dvc_timing_pkg.sv */
package dvc_timing_pkg;

    // System clock to 45 kHz decoder clock
    localparam int dclk_prescale       = 667;
    localparam int dclk_prescale_width = 10;
    localparam int dclk_width          = 32;

    // System timer runs on decoder clock ticks
    localparam int timer_cnt_width = 21;
    localparam int timer_frac_bits = 3;  // Below the compared field
    localparam int timer_cmp_width = 16;

    // Compare register value after reset
    localparam logic [15:0] tcnt_reset = 16'd55;

endpackage

/* dvc_regmap_pkg.sv */
package dvc_regmap_pkg;

    // CPU word addresses, byte address shifted right by one
    localparam logic [14:0] addr_fma_cmd    = 15'h1800;
    localparam logic [14:0] addr_fma_stat   = 15'h1801;
    localparam logic [14:0] addr_fma_ivec   = 15'h1806;
    localparam logic [14:0] addr_fma_dclkh  = 15'h1808;
    localparam logic [14:0] addr_fma_dclkl  = 15'h1809;  // Latched on DCLKH read
    localparam logic [14:0] addr_fma_isr    = 15'h180D;
    localparam logic [14:0] addr_fma_ier    = 15'h180E;
    localparam logic [14:0] addr_fmv_ier    = 15'h2030;
    localparam logic [14:0] addr_fmv_isr    = 15'h2031;
    localparam logic [14:0] addr_fmv_tcnt   = 15'h2032;
    localparam logic [14:0] addr_fmv_trld   = 15'h2057;
    localparam logic [14:0] addr_fmv_syscmd = 15'h2060;
    localparam logic [14:0] addr_fmv_ivec   = 15'h206E;
    localparam logic [14:0] addr_fmv_xfer   = 15'h206F;  // PIO stream data

    // Bit positions shared by FMA STAT and FMA ISR
    localparam int fma_bit_upd  = 2;  // Frame header updated
    localparam int fma_bit_unf  = 3;  // Underflow
    localparam int fma_bit_dec  = 4;  // Decoding started
    localparam int fma_bit_poll = 8;  // Timer poll, ISR only

    localparam int fma_cmd_dma_bit = 15;
    localparam logic [15:0] fmv_syscmd_dma = 16'h8000;

    // DMA FSM states
    localparam logic [1:0] dma_idle  = 2'd0;
    localparam logic [1:0] dma_audio = 2'd1;
    localparam logic [1:0] dma_video = 2'd2;

    // FMV interrupt flags, seq sits in bit 0
    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;    // Pause
        logic vsync;
        logic eii;    // End of ISO stream
        logic esi;    // End of sequence
        logic tim;    // System timer
        logic dcl;
        logic ovf;
        logic ndat;
        logic rfb;
        logic eod;    // End of data
        logic pic;
        logic gop;
        logic seq;
    } fmv_irq_flags_s;

    typedef union packed {
        fmv_irq_flags_s flags;
        logic [15:0]    raw;
    } fmv_irq_u;

endpackage
